// File: run.sh
#!/bin/sh
# build and run the mmu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mmu -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mmu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: verilog.f
tlb_pkg.sv
tlb_op_decode.sv
tlb.sv
xlate_result.sv
mmu_top.sv
tb_mmu_asserts.sv
tb_mmu.sv

// File: tb_mmu.sv
`timescale 1ns/100ps

module tb_mmu
    import tlb_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int N_OPS        = 3000;
    localparam int TOTAL_OPS    = N_OPS + TLB_NUM + 1;
    localparam int WATCHDOG_NS  = TOTAL_OPS * 10 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    tlb_cmd_t    cmd;
    xlate_req_t  fetch_req;
    xlate_req_t  ls_req;
    logic [9:0]  cur_asid;
    logic [1:0]  cur_plv;
    xlate_resp_t fetch_resp;
    xlate_resp_t ls_resp;
    logic        srch_valid;
    tlb_hit_t    srch_hit;
    logic        rd_valid;
    tlb_entry_t  rd_entry;

    integer      seed;
    tlb_entry_t  tlb_model [TLB_NUM];
    int          fill_ptr;
    logic [18:0] vppn_pool [4];
    logic [9:0]  asid_pool [2];

    xlate_resp_t exp_fetch_q [$];
    xlate_resp_t exp_ls_q [$];
    int          exp_srch_q [$];
    tlb_entry_t  exp_rd_q [$];

    mmu_top #(.TLB_NUM(TLB_NUM)) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .fetch_req  (fetch_req),
        .ls_req     (ls_req),
        .cur_asid   (cur_asid),
        .cur_plv    (cur_plv),
        .fetch_resp (fetch_resp),
        .ls_resp    (ls_resp),
        .srch_valid (srch_valid),
        .srch_hit   (srch_hit),
        .rd_valid   (rd_valid),
        .rd_entry   (rd_entry)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic int rand_range(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic tlb_page_t rand_page();
        tlb_page_t pg;
        pg.ppn = 20'($random(seed));
        pg.plv = 2'(rand_range(4));
        pg.mat = 2'(rand_range(4));
        pg.d   = (rand_range(2) == 1);
        pg.v   = (rand_range(4) != 0);
        return pg;
    endfunction

    // entries drawn from small pools so hits are common
    function automatic tlb_entry_t rand_entry();
        tlb_entry_t en;
        en.e     = (rand_range(8) != 0);
        en.ps4mb = (rand_range(4) == 0);
        en.vppn  = vppn_pool[rand_range(4)];
        if (en.ps4mb) begin
            en.vppn[9:0] = 10'(rand_range(1024));
        end
        en.asid  = asid_pool[rand_range(2)];
        en.g     = (rand_range(4) == 0);
        en.page0 = rand_page();
        en.page1 = rand_page();
        return en;
    endfunction

    function automatic logic [31:0] rand_va();
        logic [18:0] vp;
        vp = vppn_pool[rand_range(4)];
        // scrambled low vppn only hits 4MB pages
        if (rand_range(4) == 0) begin
            vp[9:0] = 10'(rand_range(1024));
        end
        return {vp, 1'(rand_range(2)), 12'(rand_range(4096))};
    endfunction

    function automatic logic vppn_matches(tlb_entry_t en, logic [18:0] vppn);
        return (en.vppn[18:10] == vppn[18:10]) && (en.ps4mb || (en.vppn[9:0] == vppn[9:0]));
    endfunction

    function automatic int model_find(logic [18:0] vppn, logic [9:0] asid);
        for (int i = 0; i < TLB_NUM; i++) begin
            if (tlb_model[i].e && vppn_matches(tlb_model[i], vppn) &&
                (tlb_model[i].g || (tlb_model[i].asid == asid))) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic xlate_resp_t model_xlate(xlate_req_t req, logic [9:0] asid,
                                                logic [1:0] plv);
        xlate_resp_t r;
        int          idx;
        tlb_entry_t  en;
        tlb_page_t   pg;
        logic        odd;
        r       = '0;
        r.valid = req.valid;
        idx     = model_find(req.va[31:13], asid);
        if (idx < 0) begin
            r.exc = EXC_REFILL;
            return r;
        end
        en    = tlb_model[idx];
        odd   = en.ps4mb ? req.va[22] : req.va[12];
        pg    = odd ? en.page1 : en.page0;
        r.mat = pg.mat;
        r.pa  = en.ps4mb ? {pg.ppn[19:10], req.va[21:0]} : {pg.ppn, req.va[11:0]};
        if (!pg.v) begin
            case (req.kind)
                ACC_FETCH: r.exc = EXC_PIF;
                ACC_LOAD:  r.exc = EXC_PIL;
                default:   r.exc = EXC_PIS;
            endcase
        end else if (plv > pg.plv) begin
            r.exc = EXC_PPI;
        end else if ((req.kind == ACC_STORE) && !pg.d) begin
            r.exc = EXC_PME;
        end else begin
            r.exc = EXC_NONE;
        end
        return r;
    endfunction

    task automatic model_inv(logic [4:0] op, tlb_key_t key);
        logic g;
        logic asid_eq;
        logic va_eq;
        logic sel;
        for (int i = 0; i < TLB_NUM; i++) begin
            g       = tlb_model[i].g;
            asid_eq = (tlb_model[i].asid == key.asid);
            va_eq   = vppn_matches(tlb_model[i], key.vppn);
            case (op)
                5'd0, 5'd1: sel = 1'b1;
                5'd2:       sel = g;
                5'd3:       sel = !g;
                5'd4:       sel = !g && asid_eq;
                5'd5:       sel = !g && asid_eq && va_eq;
                5'd6:       sel = (g || asid_eq) && va_eq;
                default:    sel = 1'b0;
            endcase
            if (sel) begin
                tlb_model[i].e = 1'b0;
            end
        end
    endtask

    task automatic drive_cycle(int init_idx);
        tlb_cmd_t    c;
        xlate_req_t  f;
        xlate_req_t  l;
        logic [31:0] kva;
        int          sel;
        c        = '0;
        f        = '0;
        l        = '0;
        cur_asid = asid_pool[rand_range(2)];
        cur_plv  = 2'(rand_range(4));
        if (init_idx >= 0) begin
            c.valid = 1'b1;
            c.kind  = CMD_WR;
            c.index = TLB_IDX_W'(init_idx);
            c.entry = rand_entry();
        end else if (rand_range(2) == 0) begin
            sel     = rand_range(20);
            c.valid = 1'b1;
            if (sel < 6) begin
                c.kind = CMD_WR;
            end else if (sel < 12) begin
                c.kind = CMD_FILL;
            end else if (sel < 15) begin
                c.kind = CMD_RD;
            end else if (sel < 19) begin
                c.kind = CMD_SRCH;
            end else begin
                c.kind = CMD_INV;
            end
            c.index  = TLB_IDX_W'(rand_range(TLB_NUM));
            c.inv_op = 5'(rand_range(8));
            kva      = rand_va();
            c.key    = '{vppn: kva[31:13], va_bit12: kva[12], asid: asid_pool[rand_range(2)]};
            c.entry  = rand_entry();
        end
        f.valid = (rand_range(4) != 0);
        f.va    = rand_va();
        f.kind  = ACC_FETCH;
        // port 1 is taken by search and invtlb
        if (!(c.valid && ((c.kind == CMD_SRCH) || (c.kind == CMD_INV)))) begin
            l.valid = (rand_range(4) != 0);
        end
        l.va   = rand_va();
        l.kind = (rand_range(2) == 0) ? ACC_LOAD : ACC_STORE;
        // lookups see the table before this edge's update
        exp_fetch_q.push_back(model_xlate(f, cur_asid, cur_plv));
        exp_ls_q.push_back(model_xlate(l, cur_asid, cur_plv));
        if (c.valid) begin
            case (c.kind)
                CMD_SRCH: exp_srch_q.push_back(model_find(c.key.vppn, c.key.asid));
                CMD_RD:   exp_rd_q.push_back(tlb_model[c.index]);
                CMD_WR:   tlb_model[c.index] = c.entry;
                CMD_FILL: begin
                    tlb_model[fill_ptr] = c.entry;
                    fill_ptr = (fill_ptr + 1) % TLB_NUM;
                end
                default:  model_inv(c.inv_op, c.key);
            endcase
        end
        cmd       = c;
        fetch_req = f;
        ls_req    = l;
    endtask

    task automatic compare_resp(string name, xlate_resp_t got, xlate_resp_t exp);
        assert (got.valid == exp.valid)
            else fail_now($sformatf("Mismatch %s.valid: got %h expected %h",
                                    name, got.valid, exp.valid));
        if (exp.valid) begin
            assert (got.exc == exp.exc)
                else fail_now($sformatf("Mismatch %s.exc: got %h expected %h",
                                        name, got.exc, exp.exc));
            if (exp.exc != EXC_REFILL) begin
                assert (got.pa == exp.pa)
                    else fail_now($sformatf("Mismatch %s.pa: got %h expected %h",
                                            name, got.pa, exp.pa));
                assert (got.mat == exp.mat)
                    else fail_now($sformatf("Mismatch %s.mat: got %h expected %h",
                                            name, got.mat, exp.mat));
            end
        end
    endtask

    task automatic check_outputs();
        xlate_resp_t ef;
        xlate_resp_t el;
        int          es;
        tlb_entry_t  er;
        ef = '0;
        el = '0;
        if (exp_fetch_q.size() != 0) begin
            ef = exp_fetch_q.pop_front();
        end
        if (exp_ls_q.size() != 0) begin
            el = exp_ls_q.pop_front();
        end
        compare_resp("fetch_resp", fetch_resp, ef);
        compare_resp("ls_resp", ls_resp, el);
        assert (srch_valid == (exp_srch_q.size() != 0))
            else fail_now($sformatf("Mismatch srch_valid: got %h expected %h",
                                    srch_valid, exp_srch_q.size() != 0));
        if (exp_srch_q.size() != 0) begin
            es = exp_srch_q.pop_front();
            assert (srch_hit.found == (es >= 0))
                else fail_now($sformatf("Mismatch srch_hit.found: got %h expected %h",
                                        srch_hit.found, es >= 0));
            if (es >= 0) begin
                assert (srch_hit.index == TLB_IDX_W'(es))
                    else fail_now($sformatf("Mismatch srch_hit.index: got %h expected %h",
                                            srch_hit.index, es));
            end
        end
        assert (rd_valid == (exp_rd_q.size() != 0))
            else fail_now($sformatf("Mismatch rd_valid: got %h expected %h",
                                    rd_valid, exp_rd_q.size() != 0));
        if (exp_rd_q.size() != 0) begin
            er = exp_rd_q.pop_front();
            assert (rd_entry == er)
                else fail_now($sformatf("Mismatch rd_entry: got %h expected %h",
                                        rd_entry, er));
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_now("watchdog expired before the test sequence finished");
    end

    initial begin
        wait (dut0.u_asserts.fail_count != 0);
        fail_now("a concurrent assertion bound into mmu_top failed");
    end

    initial begin
        seed         = 94278;
        fill_ptr     = 0;
        rst_n        = 1'b0;
        cmd          = '0;
        fetch_req    = '0;
        ls_req       = '0;
        cur_asid     = '0;
        cur_plv      = '0;
        vppn_pool[0] = 19'h01234;
        vppn_pool[1] = 19'h01235;
        vppn_pool[2] = 19'h2a400;
        vppn_pool[3] = 19'h5bc7f;
        asid_pool[0] = 10'h005;
        asid_pool[1] = 10'h2e1;
        for (int i = 0; i < TLB_NUM; i++) begin
            tlb_model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // every entry written once so reads never see unknown contents
        for (int i = 0; i < TLB_NUM; i++) begin
            drive_cycle(i);
            @(posedge clk);
            #1;
            check_outputs();
        end
        for (int n = 0; n < N_OPS; n++) begin
            drive_cycle(-1);
            @(posedge clk);
            #1;
            check_outputs();
        end
        cmd       = '0;
        fetch_req = '0;
        ls_req    = '0;
        @(posedge clk);
        #1;
        check_outputs();
        if (dut0.u_asserts.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail_now("a concurrent assertion bound into mmu_top failed");
        end
    end

endmodule

// File: tb_mmu_asserts.sv
`timescale 1ns/100ps

module tb_mmu_asserts
    import tlb_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input tlb_cmd_t    cmd,
    input xlate_req_t  fetch_req,
    input xlate_req_t  ls_req,
    input xlate_resp_t fetch_resp,
    input xlate_resp_t ls_resp,
    input logic        srch_valid
);

    logic srch_cmd;
    logic port1_cmd;
    int   fail_count = 0;

    assign srch_cmd  = cmd.valid && (cmd.kind == CMD_SRCH);
    assign port1_cmd = cmd.valid && ((cmd.kind == CMD_SRCH) || (cmd.kind == CMD_INV));

    fetch_resp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_resp.valid |-> $past(fetch_req.valid))
        else begin
            $error("fetch response without a request one cycle earlier");
            fail_count++;
        end

    ls_resp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        ls_resp.valid |-> $past(ls_req.valid))
        else begin
            $error("load/store response without a request one cycle earlier");
            fail_count++;
        end

    ls_idle_on_port1_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        port1_cmd |-> !ls_req.valid)
        else begin
            $error("load/store request during a search or invalidate");
            fail_count++;
        end

    srch_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        srch_cmd |=> srch_valid)
        else begin
            $error("search command not followed by srch_valid");
            fail_count++;
        end

endmodule

bind mmu_top tb_mmu_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .fetch_req  (fetch_req),
    .ls_req     (ls_req),
    .fetch_resp (fetch_resp),
    .ls_resp    (ls_resp),
    .srch_valid (srch_valid)
);

// File: mmu_top.sv
`timescale 1ns/100ps

module mmu_top
    import tlb_pkg::*;
#(
    parameter int TLB_NUM = tlb_pkg::TLB_NUM,
    localparam int TLB_IDX_W = $clog2(TLB_NUM)
) (
    input  logic        clk,
    input  logic        rst_n,
    input  tlb_cmd_t    cmd,
    input  xlate_req_t  fetch_req,
    input  xlate_req_t  ls_req,
    input  logic [9:0]  cur_asid,
    input  logic [1:0]  cur_plv,
    output xlate_resp_t fetch_resp,
    output xlate_resp_t ls_resp,
    output logic        srch_valid,
    output tlb_hit_t    srch_hit,
    output logic        rd_valid,
    output tlb_entry_t  rd_entry
);

    tlb_key_t             s0_key;
    tlb_key_t             s1_key;
    tlb_key_t             ls_key;
    tlb_hit_t             s0_hit;
    tlb_hit_t             s1_hit;
    logic                 we;
    logic [TLB_IDX_W-1:0] w_index;
    tlb_entry_t           w_entry;
    logic [TLB_IDX_W-1:0] r_index;
    logic                 inv_valid;
    logic [4:0]           inv_op;

    assign s0_key = '{vppn: fetch_req.va[31:13], va_bit12: fetch_req.va[12], asid: cur_asid};
    assign ls_key = '{vppn: ls_req.va[31:13], va_bit12: ls_req.va[12], asid: cur_asid};

    tlb_op_decode #(.TLB_NUM(TLB_NUM)) u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .ls_key     (ls_key),
        .we         (we),
        .w_index    (w_index),
        .w_entry    (w_entry),
        .s1_key     (s1_key),
        .r_index    (r_index),
        .inv_valid  (inv_valid),
        .inv_op     (inv_op),
        .srch_valid (srch_valid),
        .rd_valid   (rd_valid)
    );

    tlb #(.TLB_NUM(TLB_NUM)) u_tlb (
        .clk       (clk),
        .rst_n     (rst_n),
        .s0_key    (s0_key),
        .s0_hit    (s0_hit),
        .s1_key    (s1_key),
        .s1_hit    (s1_hit),
        .srch_hit  (srch_hit),
        .we        (we),
        .w_index   (w_index),
        .w_entry   (w_entry),
        .inv_valid (inv_valid),
        .inv_op    (inv_op),
        .r_index   (r_index),
        .r_entry   (rd_entry)
    );

    xlate_result xr_fetch (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (fetch_req),
        .hit     (s0_hit),
        .cur_plv (cur_plv),
        .resp    (fetch_resp)
    );

    xlate_result xr_ls (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (ls_req),
        .hit     (s1_hit),
        .cur_plv (cur_plv),
        .resp    (ls_resp)
    );

endmodule

// File: xlate_result.sv
`timescale 1ns/100ps

module xlate_result
    import tlb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  xlate_req_t  req,
    input  tlb_hit_t    hit,
    input  logic [1:0]  cur_plv,
    output xlate_resp_t resp
);

    logic [31:0] pa;
    exc_t        exc;

    always_comb begin
        if (hit.ps4mb) begin
            pa = {hit.page.ppn[19:10], req.va[21:0]};
        end else begin
            pa = {hit.page.ppn, req.va[11:0]};
        end
    end

    // refill, invalid, privilege, modify
    always_comb begin
        if (!hit.found) begin
            exc = EXC_REFILL;
        end else if (!hit.page.v) begin
            case (req.kind)
                ACC_FETCH: exc = EXC_PIF;
                ACC_LOAD:  exc = EXC_PIL;
                default:   exc = EXC_PIS;
            endcase
        end else if (cur_plv > hit.page.plv) begin
            exc = EXC_PPI;
        end else if ((req.kind == ACC_STORE) && !hit.page.d) begin
            exc = EXC_PME;
        end else begin
            exc = EXC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp.valid <= 1'b0;
        end else begin
            resp.valid <= req.valid;
            if (req.valid) begin
                resp.pa  <= pa;
                resp.mat <= hit.page.mat;
                resp.exc <= exc;
            end
        end
    end

endmodule

// File: tlb.sv
`timescale 1ns/100ps

module tlb
    import tlb_pkg::*;
#(
    parameter int TLB_NUM = tlb_pkg::TLB_NUM,
    localparam int TLB_IDX_W = $clog2(TLB_NUM)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  tlb_key_t             s0_key,
    output tlb_hit_t             s0_hit,
    input  tlb_key_t             s1_key,
    output tlb_hit_t             s1_hit,
    output tlb_hit_t             srch_hit,
    input  logic                 we,
    input  logic [TLB_IDX_W-1:0] w_index,
    input  tlb_entry_t           w_entry,
    input  logic                 inv_valid,
    input  logic [4:0]           inv_op,
    input  logic [TLB_IDX_W-1:0] r_index,
    output tlb_entry_t           r_entry
);

    tlb_entry_t         ent [TLB_NUM];
    logic [TLB_NUM-1:0] e_bits;

    logic [TLB_NUM-1:0] match0;
    logic [TLB_NUM-1:0] match1;

    logic [TLB_NUM-1:0] is_g;
    logic [TLB_NUM-1:0] asid_eq;
    logic [TLB_NUM-1:0] va_eq;
    logic [TLB_NUM-1:0] inv_mask;

    // low vppn bits ignored for 4MB pages
    function automatic logic va_match(tlb_key_t key, tlb_entry_t en);
        return (key.vppn[18:10] == en.vppn[18:10]) &&
               (en.ps4mb || (key.vppn[9:0] == en.vppn[9:0]));
    endfunction

    function automatic tlb_hit_t pick(logic [TLB_NUM-1:0] m, tlb_key_t key);
        tlb_hit_t             h;
        logic [TLB_IDX_W-1:0] idx;
        logic                 odd;
        idx = '0;
        // downward scan so the lowest match is left in idx
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = TLB_IDX_W'(i);
            end
        end
        odd     = ent[idx].ps4mb ? key.vppn[9] : key.va_bit12;
        h.found = |m;
        h.index = idx;
        h.ps4mb = ent[idx].ps4mb;
        h.page  = odd ? ent[idx].page1 : ent[idx].page0;
        return h;
    endfunction

    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            match0[i] = e_bits[i] && va_match(s0_key, ent[i]) &&
                        (ent[i].g || (s0_key.asid == ent[i].asid));
            match1[i] = e_bits[i] && va_match(s1_key, ent[i]) &&
                        (ent[i].g || (s1_key.asid == ent[i].asid));
        end
        s0_hit = pick(match0, s0_key);
        s1_hit = pick(match1, s1_key);
    end

    // invtlb selection against the port 1 key
    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            is_g[i]    = ent[i].g;
            asid_eq[i] = (ent[i].asid == s1_key.asid);
            va_eq[i]   = va_match(s1_key, ent[i]);
        end
        case (inv_op)
            5'd0, 5'd1: inv_mask = '1;
            5'd2:       inv_mask = is_g;
            5'd3:       inv_mask = ~is_g;
            5'd4:       inv_mask = ~is_g & asid_eq;
            5'd5:       inv_mask = ~is_g & asid_eq & va_eq;
            5'd6:       inv_mask = (is_g | asid_eq) & va_eq;
            default:    inv_mask = '0;
        endcase
    end

    always_comb begin
        r_entry   = ent[r_index];
        r_entry.e = e_bits[r_index];
    end

    always_ff @(posedge clk) begin
        if (we) begin
            ent[w_index] <= w_entry;
        end
    end

    // write wins over invalidate
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_bits <= '0;
        end else if (we) begin
            e_bits[w_index] <= w_entry.e;
        end else if (inv_valid) begin
            e_bits <= e_bits & ~inv_mask;
        end
    end

    always_ff @(posedge clk) begin
        srch_hit <= s1_hit;
    end

endmodule

// File: tlb_op_decode.sv
`timescale 1ns/100ps

module tlb_op_decode
    import tlb_pkg::*;
#(
    parameter int TLB_NUM = tlb_pkg::TLB_NUM,
    localparam int TLB_IDX_W = $clog2(TLB_NUM)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  tlb_cmd_t             cmd,
    input  tlb_key_t             ls_key,
    output logic                 we,
    output logic [TLB_IDX_W-1:0] w_index,
    output tlb_entry_t           w_entry,
    output tlb_key_t             s1_key,
    output logic [TLB_IDX_W-1:0] r_index,
    output logic                 inv_valid,
    output logic [4:0]           inv_op,
    output logic                 srch_valid,
    output logic                 rd_valid
);

    logic                 is_srch;
    logic                 is_rd;
    logic                 is_wr;
    logic                 is_fill;
    logic [TLB_IDX_W-1:0] fill_ptr;

    always_comb begin
        is_srch   = cmd.valid && (cmd.kind == CMD_SRCH);
        is_rd     = cmd.valid && (cmd.kind == CMD_RD);
        is_wr     = cmd.valid && (cmd.kind == CMD_WR);
        is_fill   = cmd.valid && (cmd.kind == CMD_FILL);
        inv_valid = cmd.valid && (cmd.kind == CMD_INV);

        we      = is_wr || is_fill;
        w_index = is_fill ? fill_ptr : cmd.index;
        w_entry = cmd.entry;
        inv_op  = cmd.inv_op;

        // port 1 is borrowed by search and invtlb
        s1_key = (is_srch || inv_valid) ? cmd.key : ls_key;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_ptr   <= '0;
            srch_valid <= 1'b0;
            rd_valid   <= 1'b0;
        end else begin
            srch_valid <= is_srch;
            rd_valid   <= is_rd;
            if (is_fill) begin
                // round robin over all entries
                fill_ptr <= (fill_ptr == TLB_IDX_W'(TLB_NUM - 1)) ? '0 : fill_ptr + 1'b1;
            end
        end
    end

    // held until the next read
    always_ff @(posedge clk) begin
        if (is_rd) begin
            r_index <= cmd.index;
        end
    end

endmodule

// File: tlb_pkg.sv
package tlb_pkg;

    parameter int TLB_NUM   = 16;
    parameter int TLB_IDX_W = $clog2(TLB_NUM);

    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_page_t;

    // page0 maps the even half, page1 the odd half
    typedef struct packed {
        logic        e;
        logic        ps4mb;
        logic [18:0] vppn;
        logic [9:0]  asid;
        logic        g;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_entry_t;

    typedef struct packed {
        logic [18:0] vppn;
        logic        va_bit12;
        logic [9:0]  asid;
    } tlb_key_t;

    typedef struct packed {
        logic                 found;
        logic [TLB_IDX_W-1:0] index;
        logic                 ps4mb;
        tlb_page_t            page;
    } tlb_hit_t;

    typedef enum logic [2:0] {
        CMD_SRCH,
        CMD_RD,
        CMD_WR,
        CMD_FILL,
        CMD_INV
    } tlb_cmd_kind_t;

    typedef struct packed {
        logic                 valid;
        tlb_cmd_kind_t        kind;
        logic [4:0]           inv_op;
        logic [TLB_IDX_W-1:0] index;
        tlb_key_t             key;
        tlb_entry_t           entry;
    } tlb_cmd_t;

    typedef enum logic [1:0] {
        ACC_FETCH,
        ACC_LOAD,
        ACC_STORE
    } acc_kind_t;

    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_REFILL,
        EXC_PIF,
        EXC_PIL,
        EXC_PIS,
        EXC_PPI,
        EXC_PME
    } exc_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] va;
        acc_kind_t   kind;
    } xlate_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pa;
        logic [1:0]  mat;
        exc_t        exc;
    } xlate_resp_t;

endpackage
